//--- src/video_pix_pkg.sv
package video_pix_pkg;

  ////////////////////////////////////////
  // Pixel encodings
  ////////////////////////////////////////

  // Framebuffer colour depth
  typedef enum logic {
    DEPTH_24 = 1'b0,
    DEPTH_16 = 1'b1
  } depth_e;

  // 24-bit colour, blue in the top byte
  typedef struct packed {
    logic [7:0] blue;
    logic [7:0] green;
    logic [7:0] red;
  } color_t;

  ////////////////////////////////////////
  // Line buffer
  ////////////////////////////////////////

  // One bank holds one line of 32-bit words
  localparam int unsigned LbBankWords = 4096;

  // Top address bit selects the bank
  localparam int unsigned LbAddrWidth = 13;

  typedef struct packed {
    logic                   we;
    logic [LbAddrWidth-1:0] addr;
    logic [31:0]            data;
  } lb_wr_t;

  // Video output bundle
  typedef struct packed {
    logic   pixel;
    logic   hsync;
    logic   vsync;
    color_t rgb;
  } video_out_t;

endpackage

//--- src/video_reg_pkg.sv
package video_reg_pkg;

  ////////////////////////////////////////
  // Register map
  ////////////////////////////////////////

  // Word addresses, taken from address bits 7 to 2
  typedef enum logic [5:0] {
    ENABLE     = 6'h00,
    POLARITY   = 6'h02,
    H_TOTAL    = 6'h08,
    H_END_DISP = 6'h09,
    H_SRT_SYNC = 6'h0A,
    H_END_SYNC = 6'h0B,
    V_TOTAL    = 6'h0C,
    V_END_DISP = 6'h0D,
    V_SRT_SYNC = 6'h0E,
    V_END_SYNC = 6'h0F,
    FB_COMMIT  = 6'h10,
    FB_WIDTH   = 6'h14,
    FB_HEIGHT  = 6'h15,
    FB_DEPTH   = 6'h16,
    BG_COLOR   = 6'h18
  } reg_addr_e;

  localparam int unsigned CntWidth   = 16;
  localparam int unsigned FbDimWidth = 12;

  // Single-cycle control request
  typedef struct packed {
    logic        en;
    logic        we;
    logic [7:0]  addr;
    logic [31:0] wdata;
  } ctrl_req_t;

  ////////////////////////////////////////
  // Configuration bundles
  ////////////////////////////////////////

  // Sync polarity of 1 gives an active-low pulse
  typedef struct packed {
    logic [CntWidth-1:0] h_total;
    logic [CntWidth-1:0] h_end_disp;
    logic [CntWidth-1:0] h_srt_sync;
    logic [CntWidth-1:0] h_end_sync;
    logic [CntWidth-1:0] v_total;
    logic [CntWidth-1:0] v_end_disp;
    logic [CntWidth-1:0] v_srt_sync;
    logic [CntWidth-1:0] v_end_sync;
    logic                hsync_pol;
    logic                vsync_pol;
  } timing_cfg_t;

  typedef struct packed {
    logic [FbDimWidth-1:0] width;
    logic [FbDimWidth-1:0] height;
    video_pix_pkg::depth_e depth;
    video_pix_pkg::color_t bg_color;
  } fb_cfg_t;

  // 640x480 at 60 Hz, negative syncs
  localparam timing_cfg_t TimingCfgDefault = '{
    h_total: 16'd800, h_end_disp: 16'd640, h_srt_sync: 16'd656, h_end_sync: 16'd752,
    v_total: 16'd525, v_end_disp: 16'd480, v_srt_sync: 16'd490, v_end_sync: 16'd492,
    hsync_pol: 1'b1, vsync_pol: 1'b1
  };

  localparam fb_cfg_t FbCfgDefault = '{
    width:    12'd640,
    height:   12'd480,
    depth:    video_pix_pkg::DEPTH_24,
    bg_color: '{blue: 8'hFF, green: 8'hFF, red: 8'hFF}
  };

endpackage

//--- src/video_reg_decode.sv
`timescale 1ns/1ps

module video_reg_decode (
  input  logic                       pxl_clk_i,
  input  logic                       rst_ni,
  input  video_reg_pkg::ctrl_req_t   ctrl_i,
  input  logic                       end_of_frame_i,
  output logic [31:0]                ctrl_rddata_o,
  output logic                       enable_o,
  output video_reg_pkg::timing_cfg_t timing_cfg_o,
  output video_reg_pkg::fb_cfg_t     fb_cfg_o
);
  import video_reg_pkg::*;
  import video_pix_pkg::*;

  reg_addr_e   addr;
  logic        wr;
  logic [31:0] rd_data;

  logic        enable_q;
  logic        commit_q;
  timing_cfg_t timing_q;

  // Shadow copy written by software, committed copy seen by the raster
  fb_cfg_t     fb_shadow_q;
  fb_cfg_t     fb_cfg_q;

  assign addr = reg_addr_e'(ctrl_i.addr[7:2]);
  assign wr   = ctrl_i.en && ctrl_i.we;

  ////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////

  always_comb begin
    case (addr)
      ENABLE:     rd_data = {31'd0, enable_q};
      POLARITY:   rd_data = {30'd0, timing_q.vsync_pol, timing_q.hsync_pol};
      H_TOTAL:    rd_data = {16'd0, timing_q.h_total};
      H_END_DISP: rd_data = {16'd0, timing_q.h_end_disp};
      H_SRT_SYNC: rd_data = {16'd0, timing_q.h_srt_sync};
      H_END_SYNC: rd_data = {16'd0, timing_q.h_end_sync};
      V_TOTAL:    rd_data = {16'd0, timing_q.v_total};
      V_END_DISP: rd_data = {16'd0, timing_q.v_end_disp};
      V_SRT_SYNC: rd_data = {16'd0, timing_q.v_srt_sync};
      V_END_SYNC: rd_data = {16'd0, timing_q.v_end_sync};
      FB_COMMIT:  rd_data = {31'd0, commit_q};
      // Geometry reads return what the raster is using
      FB_WIDTH:   rd_data = {20'd0, fb_cfg_q.width};
      FB_HEIGHT:  rd_data = {20'd0, fb_cfg_q.height};
      FB_DEPTH:   rd_data = {31'd0, fb_cfg_q.depth};
      BG_COLOR:   rd_data = {8'd0, fb_cfg_q.bg_color};
      default:    rd_data = 32'd0;
    endcase
  end

  ////////////////////////////////////////
  // Register writes
  ////////////////////////////////////////

  always_ff @(posedge pxl_clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_rddata_o <= 32'd0;
      enable_q      <= 1'b0;
      commit_q      <= 1'b0;
      timing_q      <= TimingCfgDefault;
      fb_shadow_q   <= FbCfgDefault;
      fb_cfg_q      <= FbCfgDefault;
    end else begin
      // Frame boundary is the only safe point to change geometry
      if (end_of_frame_i && commit_q) begin
        commit_q <= 1'b0;
        fb_cfg_q <= fb_shadow_q;
      end

      if (ctrl_i.en) begin
        ctrl_rddata_o <= rd_data;
      end

      if (wr) begin
        case (addr)
          ENABLE:    enable_q             <= ctrl_i.wdata[0];
          FB_COMMIT: commit_q             <= ctrl_i.wdata[0];
          FB_WIDTH:  fb_shadow_q.width    <= ctrl_i.wdata[FbDimWidth-1:0];
          FB_HEIGHT: fb_shadow_q.height   <= ctrl_i.wdata[FbDimWidth-1:0];
          FB_DEPTH:  fb_shadow_q.depth    <= depth_e'(ctrl_i.wdata[0]);
          BG_COLOR:  fb_shadow_q.bg_color <= color_t'(ctrl_i.wdata[23:0]);
          default: ;
        endcase
      end

      // Timing is locked while the display runs
      if (wr && !enable_q) begin
        case (addr)
          POLARITY: begin
            timing_q.vsync_pol <= ctrl_i.wdata[1];
            timing_q.hsync_pol <= ctrl_i.wdata[0];
          end
          H_TOTAL:    timing_q.h_total    <= ctrl_i.wdata[CntWidth-1:0];
          H_END_DISP: timing_q.h_end_disp <= ctrl_i.wdata[CntWidth-1:0];
          H_SRT_SYNC: timing_q.h_srt_sync <= ctrl_i.wdata[CntWidth-1:0];
          H_END_SYNC: timing_q.h_end_sync <= ctrl_i.wdata[CntWidth-1:0];
          V_TOTAL:    timing_q.v_total    <= ctrl_i.wdata[CntWidth-1:0];
          V_END_DISP: timing_q.v_end_disp <= ctrl_i.wdata[CntWidth-1:0];
          V_SRT_SYNC: timing_q.v_srt_sync <= ctrl_i.wdata[CntWidth-1:0];
          V_END_SYNC: timing_q.v_end_sync <= ctrl_i.wdata[CntWidth-1:0];
          default: ;
        endcase
      end
    end
  end

  assign enable_o     = enable_q;
  assign timing_cfg_o = timing_q;
  assign fb_cfg_o     = fb_cfg_q;

  // Frame end only comes from a raster that was running the cycle before
  a_eof_when_enabled: assert property (
    @(posedge pxl_clk_i) disable iff (!rst_ni)
    end_of_frame_i |-> $past(enable_o)
  ) else $error("end of frame while display disabled");

endmodule

//--- src/video_raster_timing.sv
`timescale 1ns/1ps

module video_raster_timing (
  input  logic                                  pxl_clk_i,
  input  logic                                  rst_ni,
  input  logic                                  enable_i,
  input  video_reg_pkg::timing_cfg_t            timing_cfg_i,
  input  video_reg_pkg::fb_cfg_t                fb_cfg_i,
  output logic                                  end_of_frame_o,
  output logic                                  rd_en_o,
  output logic [video_pix_pkg::LbAddrWidth-1:0] rd_addr_o,
  output logic                                  pixel_o,
  output logic                                  hsync_o,
  output logic                                  vsync_o,
  output logic                                  in_fb_o,
  output logic                                  odd_half_o
);
  import video_reg_pkg::*;
  import video_pix_pkg::*;

  logic [CntWidth-1:0] h_cnt_q;
  logic [CntWidth-1:0] v_cnt_q;
  logic                h_wrap;
  logic                v_wrap;

  logic h_in_sync;
  logic v_in_sync;
  logic pixel_d;
  logic eof_d;

  ////////////////////////////////////////
  // Counters
  ////////////////////////////////////////

  assign h_wrap = h_cnt_q == timing_cfg_i.h_total - CntWidth'(1);
  assign v_wrap = v_cnt_q == timing_cfg_i.v_total - CntWidth'(1);

  always_ff @(posedge pxl_clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      h_cnt_q <= '0;
      v_cnt_q <= '0;
    end else if (!enable_i) begin
      h_cnt_q <= '0;
      v_cnt_q <= '0;
    end else if (h_wrap) begin
      h_cnt_q <= '0;
      v_cnt_q <= v_wrap ? '0 : v_cnt_q + CntWidth'(1);
    end else begin
      h_cnt_q <= h_cnt_q + CntWidth'(1);
    end
  end

  ////////////////////////////////////////
  // Windows and line buffer request
  ////////////////////////////////////////

  assign h_in_sync = h_cnt_q >= timing_cfg_i.h_srt_sync && h_cnt_q < timing_cfg_i.h_end_sync;
  assign v_in_sync = v_cnt_q >= timing_cfg_i.v_srt_sync && v_cnt_q < timing_cfg_i.v_end_sync;

  assign pixel_d = enable_i && h_cnt_q < timing_cfg_i.h_end_disp
                 && v_cnt_q < timing_cfg_i.v_end_disp;
  assign eof_d   = enable_i && h_cnt_q == timing_cfg_i.h_end_disp
                 && v_cnt_q == timing_cfg_i.v_end_disp - CntWidth'(1);

  assign rd_en_o = enable_i && h_cnt_q < CntWidth'(fb_cfg_i.width)
                 && v_cnt_q < CntWidth'(fb_cfg_i.height);

  // Two 16-bit pixels share one word
  assign rd_addr_o = (fb_cfg_i.depth == DEPTH_16) ? {v_cnt_q[0], 1'b0, h_cnt_q[11:1]}
                                                  : {v_cnt_q[0], h_cnt_q[11:0]};

  // Outputs line up with the registered line buffer read
  always_ff @(posedge pxl_clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pixel_o        <= 1'b0;
      hsync_o        <= 1'b0;
      vsync_o        <= 1'b0;
      end_of_frame_o <= 1'b0;
      in_fb_o        <= 1'b0;
      odd_half_o     <= 1'b0;
    end else begin
      pixel_o        <= pixel_d;
      hsync_o        <= enable_i && (h_in_sync ^ timing_cfg_i.hsync_pol);
      vsync_o        <= enable_i && (v_in_sync ^ timing_cfg_i.vsync_pol);
      end_of_frame_o <= eof_d;
      in_fb_o        <= rd_en_o;
      odd_half_o     <= h_cnt_q[0];
    end
  end

  a_eof_single: assert property (
    @(posedge pxl_clk_i) disable iff (!rst_ni)
    end_of_frame_o |=> !end_of_frame_o
  ) else $error("end of frame held for two cycles");

endmodule

//--- src/video_line_buffer.sv
`timescale 1ns/1ps

module video_line_buffer (
  input  logic                                  pxl_clk_i,
  input  video_pix_pkg::lb_wr_t                 lb_wr_i,
  input  logic                                  rd_en_i,
  input  logic [video_pix_pkg::LbAddrWidth-1:0] rd_addr_i,
  output logic [31:0]                           rd_data_o
);
  import video_pix_pkg::*;

  ////////////////////////////////////////
  // Two banks, one per line parity
  ////////////////////////////////////////

  logic [31:0] mem_q [2*LbBankWords];

  // Write port
  always_ff @(posedge pxl_clk_i) begin
    if (lb_wr_i.we) begin
      mem_q[lb_wr_i.addr] <= lb_wr_i.data;
    end
  end

  // Read port, old data on a same-word collision
  always_ff @(posedge pxl_clk_i) begin
    if (rd_en_i) begin
      rd_data_o <= mem_q[rd_addr_i];
    end
  end

endmodule

//--- src/video_pixel_format.sv
`timescale 1ns/1ps

module video_pixel_format (
  input  logic                      pixel_i,
  input  logic                      hsync_i,
  input  logic                      vsync_i,
  input  logic                      in_fb_i,
  input  logic                      odd_half_i,
  input  logic [31:0]               rd_data_i,
  input  video_pix_pkg::depth_e     depth_i,
  input  video_pix_pkg::color_t     bg_color_i,
  output video_pix_pkg::video_out_t video_o
);
  import video_pix_pkg::*;

  logic [15:0] half_word;
  color_t      rgb565;
  color_t      rgb;

  assign half_word = odd_half_i ? rd_data_i[31:16] : rd_data_i[15:0];

  // Widen r5g6b5 by repeating the top bits of each field
  assign rgb565.red   = {half_word[15:11], half_word[15:13]};
  assign rgb565.green = {half_word[10:5], half_word[10:9]};
  assign rgb565.blue  = {half_word[4:0], half_word[4:2]};

  always_comb begin
    rgb = '0;
    if (pixel_i) begin
      if (!in_fb_i) begin
        rgb = bg_color_i;
      end else if (depth_i == DEPTH_16) begin
        rgb = rgb565;
      end else begin
        rgb = color_t'(rd_data_i[23:0]);
      end
    end
  end

  assign video_o = '{pixel: pixel_i, hsync: hsync_i, vsync: vsync_i, rgb: rgb};

endmodule

//--- src/video_top.sv
`timescale 1ns/1ps

module video_top (
  input  logic                      pxl_clk_i,
  input  logic                      rst_ni,
  input  video_reg_pkg::ctrl_req_t  ctrl_i,
  output logic [31:0]               ctrl_rddata_o,
  input  video_pix_pkg::lb_wr_t     lb_wr_i,
  output video_pix_pkg::video_out_t video_o
);
  import video_reg_pkg::*;
  import video_pix_pkg::*;

  logic                   enable;
  timing_cfg_t            timing_cfg;
  fb_cfg_t                fb_cfg;
  logic                   end_of_frame;
  logic                   rd_en;
  logic [LbAddrWidth-1:0] rd_addr;
  logic [31:0]            rd_data;
  logic                   pixel;
  logic                   hsync;
  logic                   vsync;
  logic                   in_fb;
  logic                   odd_half;

  // Decode stage
  video_reg_decode u_decode (
    .pxl_clk_i,
    .rst_ni,
    .ctrl_i,
    .end_of_frame_i (end_of_frame),
    .ctrl_rddata_o,
    .enable_o       (enable),
    .timing_cfg_o   (timing_cfg),
    .fb_cfg_o       (fb_cfg)
  );

  // Execute stage
  video_raster_timing u_timing (
    .pxl_clk_i,
    .rst_ni,
    .enable_i       (enable),
    .timing_cfg_i   (timing_cfg),
    .fb_cfg_i       (fb_cfg),
    .end_of_frame_o (end_of_frame),
    .rd_en_o        (rd_en),
    .rd_addr_o      (rd_addr),
    .pixel_o        (pixel),
    .hsync_o        (hsync),
    .vsync_o        (vsync),
    .in_fb_o        (in_fb),
    .odd_half_o     (odd_half)
  );

  video_line_buffer u_line_buffer (
    .pxl_clk_i,
    .lb_wr_i,
    .rd_en_i   (rd_en),
    .rd_addr_i (rd_addr),
    .rd_data_o (rd_data)
  );

  // Result stage
  video_pixel_format u_format (
    .pixel_i    (pixel),
    .hsync_i    (hsync),
    .vsync_i    (vsync),
    .in_fb_i    (in_fb),
    .odd_half_i (odd_half),
    .rd_data_i  (rd_data),
    .depth_i    (fb_cfg.depth),
    .bg_color_i (fb_cfg.bg_color),
    .video_o
  );

endmodule

//--- test/tb_video_top.sv
`timescale 1ns/1ps

module tb_video_top;
  import video_reg_pkg::*;
  import video_pix_pkg::*;

  // Longest frame is 40 x 14 cycles
  localparam int FrameMax   = 40 * 14;
  localparam int TestLen    = 20 + 120 + 132 + 2 * FrameMax + 2 * (2 * FrameMax + 16)
                            + 3 * FrameMax + 40;
  localparam int CycleLimit = TestLen + TestLen / 10;

  logic        pxl_clk;
  logic        rst_n;
  ctrl_req_t   ctrl;
  logic [31:0] ctrl_rddata;
  lb_wr_t      lb_wr;
  video_out_t  video;

  int   seed = 32'h21fc_3328;
  int   errors;
  int   cycles = 0;
  logic checking;
  int   ht;
  int   hd;
  int   vt;
  int   vd;

  // Reference model state
  logic                   m_enable;
  logic                   m_commit;
  logic                   m_eof;
  timing_cfg_t            m_timing;
  fb_cfg_t                m_shadow;
  fb_cfg_t                m_fb;
  logic [CntWidth-1:0]    m_h;
  logic [CntWidth-1:0]    m_v;
  logic [31:0]            m_mem [2*LbBankWords];
  logic [31:0]            m_rdata;
  logic                   p_pixel;
  logic                   p_hsync;
  logic                   p_vsync;
  logic                   p_in_fb;
  logic                   p_odd;
  logic [31:0]            p_data;
  video_out_t             exp_video;

  video_top UUT (
    .pxl_clk_i     (pxl_clk),
    .rst_ni        (rst_n),
    .ctrl_i        (ctrl),
    .ctrl_rddata_o (ctrl_rddata),
    .lb_wr_i       (lb_wr),
    .video_o       (video)
  );

  initial begin
    pxl_clk = 1'b0;
    forever #20 pxl_clk = ~pxl_clk;
  end

  always @(posedge pxl_clk) begin
    cycles++;
    if (cycles > CycleLimit) begin
      $display("Timeout after %0d cycles, test sequence did not finish", cycles);
      $display("Check summary: %0d errors", errors);
      $display("Simulation failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  function automatic int rand_range(int lo, int hi);
    int r;
    r = $random(seed) & 32'h7fff_ffff;
    return lo + r % (hi - lo + 1);
  endfunction

  function automatic logic [31:0] model_read(logic [5:0] a);
    case (reg_addr_e'(a))
      ENABLE:     return {31'd0, m_enable};
      POLARITY:   return {30'd0, m_timing.vsync_pol, m_timing.hsync_pol};
      H_TOTAL:    return {16'd0, m_timing.h_total};
      H_END_DISP: return {16'd0, m_timing.h_end_disp};
      H_SRT_SYNC: return {16'd0, m_timing.h_srt_sync};
      H_END_SYNC: return {16'd0, m_timing.h_end_sync};
      V_TOTAL:    return {16'd0, m_timing.v_total};
      V_END_DISP: return {16'd0, m_timing.v_end_disp};
      V_SRT_SYNC: return {16'd0, m_timing.v_srt_sync};
      V_END_SYNC: return {16'd0, m_timing.v_end_sync};
      FB_COMMIT:  return {31'd0, m_commit};
      FB_WIDTH:   return {20'd0, m_fb.width};
      FB_HEIGHT:  return {20'd0, m_fb.height};
      FB_DEPTH:   return {31'd0, m_fb.depth};
      BG_COLOR:   return {8'd0, m_fb.bg_color};
      default:    return 32'd0;
    endcase
  endfunction

  // Timing fields only change while the display is stopped
  task automatic model_write(logic [5:0] a, logic [31:0] d, logic locked);
    case (reg_addr_e'(a))
      ENABLE:    m_enable = d[0];
      FB_COMMIT: m_commit = d[0];
      FB_WIDTH:  m_shadow.width = d[11:0];
      FB_HEIGHT: m_shadow.height = d[11:0];
      FB_DEPTH:  m_shadow.depth = depth_e'(d[0]);
      BG_COLOR:  m_shadow.bg_color = color_t'(d[23:0]);
      POLARITY: begin
        if (!locked) begin
          m_timing.hsync_pol = d[0];
          m_timing.vsync_pol = d[1];
        end
      end
      H_TOTAL:    if (!locked) m_timing.h_total = d[15:0];
      H_END_DISP: if (!locked) m_timing.h_end_disp = d[15:0];
      H_SRT_SYNC: if (!locked) m_timing.h_srt_sync = d[15:0];
      H_END_SYNC: if (!locked) m_timing.h_end_sync = d[15:0];
      V_TOTAL:    if (!locked) m_timing.v_total = d[15:0];
      V_END_DISP: if (!locked) m_timing.v_end_disp = d[15:0];
      V_SRT_SYNC: if (!locked) m_timing.v_srt_sync = d[15:0];
      V_END_SYNC: if (!locked) m_timing.v_end_sync = d[15:0];
      default: ;
    endcase
  endtask

  function automatic color_t expected_rgb();
    logic [15:0] hw;
    logic [4:0]  r5;
    logic [5:0]  g6;
    logic [4:0]  b5;
    hw = p_odd ? p_data[31:16] : p_data[15:0];
    r5 = hw[15:11];
    g6 = hw[10:5];
    b5 = hw[4:0];
    if (!p_pixel) return '0;
    if (!p_in_fb) return m_fb.bg_color;
    if (m_fb.depth == DEPTH_16) begin
      return '{blue: {b5, b5[4:2]}, green: {g6, g6[5:4]}, red: {r5, r5[4:2]}};
    end
    return color_t'(p_data[23:0]);
  endfunction

  task automatic step_model();
    logic                   in_fb_now;
    logic [LbAddrWidth-1:0] addr_now;
    logic                   eof_next;
    if (ctrl.en) m_rdata = model_read(ctrl.addr[7:2]);
    // Stage in front of the formatter, one cycle behind the counters
    in_fb_now = m_enable && m_h < CntWidth'(m_fb.width) && m_v < CntWidth'(m_fb.height);
    addr_now  = {m_v[0], 12'((m_fb.depth == DEPTH_16) ? m_h >> 1 : m_h)};
    if (in_fb_now) p_data = m_mem[addr_now];
    p_in_fb  = in_fb_now;
    p_odd    = m_h[0];
    p_pixel  = m_enable && m_h < m_timing.h_end_disp && m_v < m_timing.v_end_disp;
    p_hsync  = m_enable && ((m_h >= m_timing.h_srt_sync && m_h < m_timing.h_end_sync)
                            != m_timing.hsync_pol);
    p_vsync  = m_enable && ((m_v >= m_timing.v_srt_sync && m_v < m_timing.v_end_sync)
                            != m_timing.vsync_pol);
    eof_next = m_enable && m_h == m_timing.h_end_disp && m_v == m_timing.v_end_disp - 16'd1;
    if (!m_enable) begin
      m_h = '0;
      m_v = '0;
    end else if (m_h == m_timing.h_total - 16'd1) begin
      m_h = '0;
      m_v = (m_v == m_timing.v_total - 16'd1) ? '0 : m_v + 16'd1;
    end else begin
      m_h = m_h + 16'd1;
    end
    if (m_eof && m_commit) begin
      m_fb     = m_shadow;
      m_commit = 1'b0;
    end
    m_eof = eof_next;
    if (ctrl.en && ctrl.we) model_write(ctrl.addr[7:2], ctrl.wdata, m_enable);
    if (lb_wr.we) m_mem[lb_wr.addr] = lb_wr.data;
    exp_video = '{pixel: p_pixel, hsync: p_hsync, vsync: p_vsync, rgb: expected_rgb()};
  endtask

  always @(posedge pxl_clk or negedge rst_n) begin
    if (!rst_n) begin
      m_enable  = 1'b0;
      m_commit  = 1'b0;
      m_eof     = 1'b0;
      m_h       = '0;
      m_v       = '0;
      m_timing  = '{h_total: 16'd800, h_end_disp: 16'd640, h_srt_sync: 16'd656,
                    h_end_sync: 16'd752, v_total: 16'd525, v_end_disp: 16'd480,
                    v_srt_sync: 16'd490, v_end_sync: 16'd492, hsync_pol: 1'b1, vsync_pol: 1'b1};
      m_fb      = '{width: 12'd640, height: 12'd480, depth: DEPTH_24,
                    bg_color: '{blue: 8'hFF, green: 8'hFF, red: 8'hFF}};
      m_shadow  = m_fb;
      exp_video = '0;
    end else begin
      step_model();
    end
  end

  ////////////////////////////////////////
  // Checks and bus tasks
  ////////////////////////////////////////

  task automatic check_video(video_out_t exp, video_out_t act);
    if (act !== exp) begin
      errors++;
      $display("ERROR at %0t: video_o expected pix %b hs %b vs %b rgb %h, got %b %b %b %h",
               $time, exp.pixel, exp.hsync, exp.vsync, exp.rgb,
               act.pixel, act.hsync, act.vsync, act.rgb);
    end
  endtask

  task automatic check_rd(logic [31:0] exp, logic [31:0] act);
    if (act !== exp) begin
      errors++;
      $display("ERROR at %0t: ctrl_rddata_o expected %h got %h", $time, exp, act);
    end
  endtask

  always @(negedge pxl_clk) begin
    if (checking) check_video(exp_video, video);
  end

  task automatic reg_write(logic [5:0] a, logic [31:0] d);
    ctrl = '{en: 1'b1, we: 1'b1, addr: {a, 2'b00}, wdata: d};
    @(posedge pxl_clk);
    #2;
    ctrl = '0;
  endtask

  task automatic reg_read(logic [5:0] a);
    ctrl = '{en: 1'b1, we: 1'b0, addr: {a, 2'b00}, wdata: 32'd0};
    @(posedge pxl_clk);
    #2;
    ctrl = '0;
    check_rd(m_rdata, ctrl_rddata);
  endtask

  task automatic read_all_regs();
    reg_addr_e a;
    a = a.first();
    do begin
      reg_read(a);
      a = a.next();
    end while (a != a.first());
    // Unmapped word
    reg_read(6'h01);
  endtask

  task automatic read_timing();
    reg_read(POLARITY);
    for (int i = H_TOTAL; i <= V_END_SYNC; i++) reg_read(6'(i));
  endtask

  task automatic write_timing(int he, int ve, int pol);
    reg_write(H_TOTAL, ht);
    reg_write(H_END_DISP, hd);
    reg_write(H_SRT_SYNC, hd + 1);
    reg_write(H_END_SYNC, he);
    reg_write(V_TOTAL, vt);
    reg_write(V_END_DISP, vd);
    reg_write(V_SRT_SYNC, vd + 1);
    reg_write(V_END_SYNC, ve);
    reg_write(POLARITY, pol);
  endtask

  task automatic fill_line_buffer();
    for (int bank = 0; bank < 2; bank++) begin
      for (int word = 0; word < 64; word++) begin
        lb_wr = '{we: 1'b1, addr: LbAddrWidth'(bank * LbBankWords + word), data: $random(seed)};
        @(posedge pxl_clk);
        #2;
      end
    end
    lb_wr = '0;
  endtask

  task automatic wait_frames(int n);
    repeat (n * ht * vt) @(posedge pxl_clk);
    #2;
  endtask

  // Poll until the pending commit has been taken at a frame end
  task automatic wait_commit();
    int n;
    n = 0;
    do begin
      reg_read(FB_COMMIT);
      n++;
    end while (ctrl_rddata[0] && n < ht * vt + 10);
    if (ctrl_rddata[0]) begin
      errors++;
      $display("Framebuffer commit was not applied within one frame at %0t", $time);
    end
  endtask

  task automatic read_fb_regs();
    reg_read(FB_WIDTH);
    reg_read(FB_HEIGHT);
    reg_read(FB_DEPTH);
    reg_read(BG_COLOR);
  endtask

  // Window kept inside the display area so the background shows
  task automatic set_fb(depth_e d, logic commit);
    reg_write(FB_WIDTH, rand_range(2, hd - 1));
    reg_write(FB_HEIGHT, rand_range(1, vd - 1));
    reg_write(FB_DEPTH, {31'd0, d});
    reg_write(BG_COLOR, {8'd0, 24'($random(seed))});
    if (commit) begin
      reg_write(FB_COMMIT, 32'd1);
      wait_commit();
    end
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    ctrl     = '0;
    lb_wr    = '0;
    rst_n    = 1'b0;
    errors   = 0;
    checking = 1'b0;
    repeat (16) @(posedge pxl_clk);
    #2;
    rst_n    = 1'b1;
    checking = 1'b1;

    read_all_regs();
    fill_line_buffer();

    ht = rand_range(20, 40);
    hd = rand_range(ht / 2, ht - 4);
    vt = rand_range(8, 14);
    vd = rand_range(4, vt - 3);
    write_timing(rand_range(hd + 2, ht - 1), rand_range(vd + 2, vt - 1), rand_range(0, 3));
    read_timing();
    reg_write(ENABLE, 32'd1);
    // Locked now, these writes must not land
    for (int i = H_TOTAL; i <= V_END_SYNC; i++) reg_write(6'(i), $random(seed));
    reg_write(POLARITY, $random(seed));
    read_timing();

    wait_frames(2);

    set_fb(DEPTH_24, 1'b1);
    wait_frames(1);
    set_fb(DEPTH_16, 1'b1);
    wait_frames(1);

    set_fb(DEPTH_24, 1'b0);
    read_fb_regs();
    wait_frames(1);
    reg_read(FB_COMMIT);
    reg_write(FB_COMMIT, 32'd1);
    reg_read(FB_COMMIT);
    wait_commit();
    read_fb_regs();
    wait_frames(1);

    $display("Check summary: %0d errors", errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- flist.f
src/video_pix_pkg.sv
src/video_reg_pkg.sv
src/video_reg_decode.sv
src/video_raster_timing.sv
src/video_line_buffer.sv
src/video_pixel_format.sv
src/video_top.sv
test/tb_video_top.sv

//--- run.sh
#!/bin/sh
# Build and run the video core testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_video_top -f flist.f -o tb_video_top
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_video_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation run returned status $status"
  exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
  exit 1
fi
exit 0
